// File: build.f
common/psg_pkg.sv
common/psg_regs_if.sv
psg/psg_regfile.sv
psg/psg_tone_bank.sv
psg/psg_noise_gen.sv
psg/psg_envelope_gen.sv
psg/psg_mixer.sv
verilog/psg_top.sv
tb/psg_clk_gen.sv
tb/psg_tb.sv

// File: common/psg_pkg.sv
package psg_pkg;

    typedef logic [11:0] tone_period_t;
    typedef logic [4:0]  noise_period_t;
    typedef logic [15:0] env_period_t;
    typedef logic [3:0]  volume_t;
    typedef logic [9:0]  level_t;

    // CPU register map
    typedef enum logic [3:0] {
        reg_tone_a_lo   = 4'h0,
        reg_tone_a_hi   = 4'h1,
        reg_tone_b_lo   = 4'h2,
        reg_tone_b_hi   = 4'h3,
        reg_tone_c_lo   = 4'h4,
        reg_tone_c_hi   = 4'h5,
        reg_noise       = 4'h6,
        reg_mixer       = 4'h7,
        reg_vol_a       = 4'h8,
        reg_vol_b       = 4'h9,
        reg_vol_c       = 4'hA,
        reg_env_lo      = 4'hB,
        reg_env_hi      = 4'hC,
        reg_env_shape   = 4'hD,
        reg_io_a        = 4'hE,
        reg_io_b        = 4'hF
    } reg_addr_e;

    typedef enum logic {
        env_run,
        env_stop
    } env_state_e;

    // Roughly 3 dB per step up to full scale 1023
    function automatic level_t volume_level(volume_t vol);
        level_t lvl;
        case (vol)
            4'h0: lvl = 10'd0;
            4'h1: lvl = 10'd6;
            4'h2: lvl = 10'd9;
            4'h3: lvl = 10'd13;
            4'h4: lvl = 10'd19;
            4'h5: lvl = 10'd27;
            4'h6: lvl = 10'd39;
            4'h7: lvl = 10'd56;
            4'h8: lvl = 10'd80;
            4'h9: lvl = 10'd116;
            4'hA: lvl = 10'd166;
            4'hB: lvl = 10'd239;
            4'hC: lvl = 10'd344;
            4'hD: lvl = 10'd495;
            4'hE: lvl = 10'd712;
            default: lvl = 10'd1023;
        endcase
        return lvl;
    endfunction

endpackage

// File: common/psg_regs_if.sv
`timescale 1ns/1ps

interface psg_regs_if;

    psg_pkg::tone_period_t  tone_period_a;
    psg_pkg::tone_period_t  tone_period_b;
    psg_pkg::tone_period_t  tone_period_c;
    psg_pkg::noise_period_t noise_period;

    // Active low enables with channel A in bit 0
    logic [2:0]             tone_n;
    logic [2:0]             noise_n;

    // Bit 4 selects the envelope
    logic [4:0]             vol_a;
    logic [4:0]             vol_b;
    logic [4:0]             vol_c;

    psg_pkg::env_period_t   env_period;
    logic                   env_hold;
    logic                   env_alternate;
    logic                   env_attack;
    logic                   env_continue;
    logic                   env_restart;

    modport regs (
        output tone_period_a, tone_period_b, tone_period_c, noise_period,
        output tone_n, noise_n, vol_a, vol_b, vol_c,
        output env_period, env_hold, env_alternate, env_attack, env_continue,
        output env_restart
    );

    modport tone (input tone_period_a, tone_period_b, tone_period_c);

    modport noise (input noise_period);

    modport env (
        input env_period, env_hold, env_alternate, env_attack, env_continue, env_restart
    );

    modport mix (input tone_n, noise_n, vol_a, vol_b, vol_c);

endinterface

// File: psg/psg_envelope_gen.sv
`timescale 1ns/1ps

module psg_envelope_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,
    psg_regs_if.env             regs,
    output psg_pkg::volume_t    env_volume
);

    logic [16:0]          period_cnt_q;
    logic                 step;

    psg_pkg::volume_t     env_cnt_q;
    logic                 count_up_q;
    logic                 restart_pend_q;
    psg_pkg::env_state_e  state_q;

    //////////////////////////////
    // Period counter
    //////////////////////////////

    // Step every 2*env_period+1 ticks
    assign step = tick && (period_cnt_q >= {regs.env_period, 1'b0});

    always_ff @(posedge clk) begin
        if (reset) begin
            period_cnt_q <= '0;
        end else if (tick) begin
            period_cnt_q <= step ? '0 : period_cnt_q + 1'b1;
        end
    end

    //////////////////////////////
    // Shape FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            env_cnt_q      <= '0;
            count_up_q     <= 1'b0;
            restart_pend_q <= 1'b0;
            state_q        <= psg_pkg::env_stop;
            env_volume     <= '0;
        end else begin
            if (step) begin
                if (state_q == psg_pkg::env_run) begin
                    env_cnt_q <= env_cnt_q - 1'b1;
                    // End of one ramp
                    if (env_cnt_q == '0) begin
                        if (!regs.env_continue || regs.env_hold) begin
                            env_cnt_q <= '0;
                            state_q   <= psg_pkg::env_stop;
                        end
                        if ((regs.env_continue && regs.env_alternate) ||
                            (!regs.env_continue && regs.env_attack)) begin
                            count_up_q <= !count_up_q;
                        end
                    end
                end

                // Counter runs down and rising shapes invert it
                env_volume <= count_up_q ? ~env_cnt_q : env_cnt_q;

                if (restart_pend_q) begin
                    restart_pend_q <= 1'b0;
                    env_cnt_q      <= 4'd15;
                    count_up_q     <= regs.env_attack;
                    state_q        <= psg_pkg::env_run;
                end
            end

            // Held until the next step
            if (regs.env_restart) begin
                restart_pend_q <= 1'b1;
            end
        end
    end

endmodule

// File: psg/psg_mixer.sv
`timescale 1ns/1ps

module psg_mixer (
    input  logic                clk,
    input  logic                reset,
    input  logic                tick,
    input  logic [2:0]          tone_out,
    input  logic                noise_bit,
    psg_regs_if.mix             regs,
    input  psg_pkg::volume_t    env_volume,
    output psg_pkg::level_t     ch_a,
    output psg_pkg::level_t     ch_b,
    output psg_pkg::level_t     ch_c
);

    logic [4:0]        vol_reg [3];
    logic [2:0]        active;
    psg_pkg::volume_t  volume [3];
    psg_pkg::level_t   level_q [3];

    assign vol_reg[0] = regs.vol_a;
    assign vol_reg[1] = regs.vol_b;
    assign vol_reg[2] = regs.vol_c;

    // A disabled source counts as high
    assign active = (tone_out | regs.tone_n) & ({3{noise_bit}} | regs.noise_n);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            if (!active[i]) begin
                volume[i] = '0;
            end else if (vol_reg[i][4]) begin
                volume[i] = env_volume;
            end else begin
                volume[i] = vol_reg[i][3:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                level_q[i] <= '0;
            end
        end else if (tick) begin
            for (int i = 0; i < 3; i++) begin
                level_q[i] <= psg_pkg::volume_level(volume[i]);
            end
        end
    end

    assign ch_a = level_q[0];
    assign ch_b = level_q[1];
    assign ch_c = level_q[2];

endmodule

// File: psg/psg_noise_gen.sv
`timescale 1ns/1ps

module psg_noise_gen (
    input  logic        clk,
    input  logic        reset,
    input  logic        tick,
    psg_regs_if.noise   regs,
    output logic        noise_bit
);

    psg_pkg::noise_period_t count_q;
    logic                   half_q;
    logic [16:0]            lfsr_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
            half_q  <= 1'b0;
            lfsr_q  <= 17'd1;
        end else if (tick) begin
            if (count_q >= regs.noise_period) begin
                count_q <= '0;
                half_q  <= !half_q;
                // Shift on every second period
                if (half_q) begin
                    lfsr_q <= {lfsr_q[0] ^ lfsr_q[3], lfsr_q[16:1]};
                end
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign noise_bit = lfsr_q[0];

endmodule

// File: psg/psg_regfile.sv
`timescale 1ns/1ps

module psg_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        a0,
    input  logic        wren,
    input  logic [7:0]  wrdata,
    output logic [7:0]  rddata,
    input  logic [7:0]  io_a_in,
    input  logic [7:0]  io_b_in,
    psg_regs_if.regs    regs
);

    psg_pkg::reg_addr_e     addr_q;

    psg_pkg::tone_period_t  tone_a_q;
    psg_pkg::tone_period_t  tone_b_q;
    psg_pkg::tone_period_t  tone_c_q;
    psg_pkg::noise_period_t noise_q;
    logic [7:0]             mixer_q;
    logic [4:0]             vol_a_q;
    logic [4:0]             vol_b_q;
    logic [4:0]             vol_c_q;
    psg_pkg::env_period_t   env_period_q;
    // {continue, attack, alternate, hold}
    logic [3:0]             shape_q;
    logic [7:0]             io_a_q;
    logic [7:0]             io_b_q;

    logic                   data_wr;

    assign data_wr = wren && !a0;

    //////////////////////////////
    // Address latch and registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q       <= psg_pkg::reg_tone_a_lo;
            tone_a_q     <= '0;
            tone_b_q     <= '0;
            tone_c_q     <= '0;
            noise_q      <= '0;
            // Tone and noise off and both ports input
            mixer_q      <= 8'h3F;
            vol_a_q      <= '0;
            vol_b_q      <= '0;
            vol_c_q      <= '0;
            env_period_q <= '0;
            shape_q      <= '0;
            io_a_q       <= '0;
            io_b_q       <= '0;
        end else if (wren && a0) begin
            addr_q <= psg_pkg::reg_addr_e'(wrdata[3:0]);
        end else if (data_wr) begin
            case (addr_q)
                psg_pkg::reg_tone_a_lo: tone_a_q[7:0]      <= wrdata;
                psg_pkg::reg_tone_a_hi: tone_a_q[11:8]     <= wrdata[3:0];
                psg_pkg::reg_tone_b_lo: tone_b_q[7:0]      <= wrdata;
                psg_pkg::reg_tone_b_hi: tone_b_q[11:8]     <= wrdata[3:0];
                psg_pkg::reg_tone_c_lo: tone_c_q[7:0]      <= wrdata;
                psg_pkg::reg_tone_c_hi: tone_c_q[11:8]     <= wrdata[3:0];
                psg_pkg::reg_noise:     noise_q            <= wrdata[4:0];
                psg_pkg::reg_mixer:     mixer_q            <= wrdata;
                psg_pkg::reg_vol_a:     vol_a_q            <= wrdata[4:0];
                psg_pkg::reg_vol_b:     vol_b_q            <= wrdata[4:0];
                psg_pkg::reg_vol_c:     vol_c_q            <= wrdata[4:0];
                psg_pkg::reg_env_lo:    env_period_q[7:0]  <= wrdata;
                psg_pkg::reg_env_hi:    env_period_q[15:8] <= wrdata;
                psg_pkg::reg_env_shape: shape_q            <= wrdata[3:0];
                psg_pkg::reg_io_a:      io_a_q             <= wrdata;
                psg_pkg::reg_io_b:      io_b_q             <= wrdata;
            endcase
        end
    end

    //////////////////////////////
    // Readback
    //////////////////////////////

    always_comb begin
        case (addr_q)
            psg_pkg::reg_tone_a_lo: rddata = tone_a_q[7:0];
            psg_pkg::reg_tone_a_hi: rddata = {4'b0, tone_a_q[11:8]};
            psg_pkg::reg_tone_b_lo: rddata = tone_b_q[7:0];
            psg_pkg::reg_tone_b_hi: rddata = {4'b0, tone_b_q[11:8]};
            psg_pkg::reg_tone_c_lo: rddata = tone_c_q[7:0];
            psg_pkg::reg_tone_c_hi: rddata = {4'b0, tone_c_q[11:8]};
            psg_pkg::reg_noise:     rddata = {3'b0, noise_q};
            psg_pkg::reg_mixer:     rddata = mixer_q;
            psg_pkg::reg_vol_a:     rddata = {3'b0, vol_a_q};
            psg_pkg::reg_vol_b:     rddata = {3'b0, vol_b_q};
            psg_pkg::reg_vol_c:     rddata = {3'b0, vol_c_q};
            psg_pkg::reg_env_lo:    rddata = env_period_q[7:0];
            psg_pkg::reg_env_hi:    rddata = env_period_q[15:8];
            psg_pkg::reg_env_shape: rddata = {4'b0, shape_q};
            // A port set as output reads its latch back
            psg_pkg::reg_io_a:      rddata = mixer_q[6] ? io_a_q : io_a_in;
            default:                rddata = mixer_q[7] ? io_b_q : io_b_in;
        endcase
    end

    //////////////////////////////
    // Decoded values to the sound blocks
    //////////////////////////////

    assign regs.tone_period_a = tone_a_q;
    assign regs.tone_period_b = tone_b_q;
    assign regs.tone_period_c = tone_c_q;
    assign regs.noise_period  = noise_q;
    assign regs.tone_n        = mixer_q[2:0];
    assign regs.noise_n       = mixer_q[5:3];
    assign regs.vol_a         = vol_a_q;
    assign regs.vol_b         = vol_b_q;
    assign regs.vol_c         = vol_c_q;
    assign regs.env_period    = env_period_q;
    assign regs.env_hold      = shape_q[0];
    assign regs.env_alternate = shape_q[1];
    assign regs.env_attack    = shape_q[2];
    assign regs.env_continue  = shape_q[3];

    // Every shape write restarts the envelope
    assign regs.env_restart   = data_wr && (addr_q == psg_pkg::reg_env_shape);

endmodule

// File: psg/psg_tone_bank.sv
`timescale 1ns/1ps

module psg_tone_bank #(
    parameter int PRESCALE_DIV = 128
) (
    input  logic        clk,
    input  logic        reset,
    psg_regs_if.tone    regs,
    output logic        tick,
    output logic [2:0]  tone_out
);

    localparam int DIV_W = (PRESCALE_DIV > 1) ? $clog2(PRESCALE_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PRESCALE_DIV - 1);

    logic [DIV_W-1:0]      div_q;
    psg_pkg::tone_period_t period [3];
    psg_pkg::tone_period_t count_q [3];

    //////////////////////////////
    // Prescaler
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            div_q <= '0;
            tick  <= 1'b0;
        end else begin
            div_q <= (div_q == DIV_LAST) ? '0 : div_q + 1'b1;
            // High for the one cycle after the wrap
            tick  <= (div_q == DIV_LAST);
        end
    end

    //////////////////////////////
    // Tone counters
    //////////////////////////////

    assign period[0] = regs.tone_period_a;
    assign period[1] = regs.tone_period_b;
    assign period[2] = regs.tone_period_c;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                count_q[i] <= '0;
            end
            tone_out <= '0;
        end else if (tick) begin
            for (int i = 0; i < 3; i++) begin
                // >= so a period lowered below the count wraps at once
                if (count_q[i] >= period[i]) begin
                    count_q[i]  <= '0;
                    tone_out[i] <= !tone_out[i];
                end else begin
                    count_q[i]  <= count_q[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module psg_tb -f build.f -o psg_sim

# A failing run is judged from the log below
./obj_dir/psg_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failure"

// File: tb/psg_clk_gen.sv
`timescale 1ns/1ps

module psg_clk_gen (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = !clk;
    end

    // Held for the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tb/psg_tb.sv
`timescale 1ns/1ps

module psg_tb;

    localparam int PRESCALE_DIV = 8;
    // Longest single wait in clocks
    localparam int WAIT_LIMIT   = 4000;

    logic              clk;
    logic              reset;
    logic              a0;
    logic              wren;
    logic [7:0]        wrdata;
    logic [7:0]        rddata;
    logic [7:0]        io_a_in;
    logic [7:0]        io_b_in;
    psg_pkg::level_t   ch_a;
    psg_pkg::level_t   ch_b;
    psg_pkg::level_t   ch_c;

    logic [31:0]       lcg_state   = 32'h0d91_800b;
    psg_pkg::level_t   level_table [16];
    logic              tone_phase  = 1'b0;
    logic              env_falling = 1'b0;

    psg_clk_gen clk_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    psg_top #(
        .PRESCALE_DIV (PRESCALE_DIV)
    ) psg_top_inst (
        .clk     (clk),
        .reset   (reset),
        .a0      (a0),
        .wren    (wren),
        .wrdata  (wrdata),
        .rddata  (rddata),
        .io_a_in (io_a_in),
        .io_b_in (io_b_in),
        .ch_a    (ch_a),
        .ch_b    (ch_b),
        .ch_c    (ch_c)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Implemented bits of each register
    function automatic logic [7:0] reg_mask(input logic [3:0] addr);
        case (addr)
            4'h1, 4'h3, 4'h5, 4'hD: return 8'h0F;
            4'h6, 4'h8, 4'h9, 4'hA: return 8'h1F;
            default:                return 8'hFF;
        endcase
    endfunction

    function automatic psg_pkg::level_t channel_level(input int ch);
        case (ch)
            0:       return ch_a;
            1:       return ch_b;
            default: return ch_c;
        endcase
    endfunction

    function automatic logic level_known(input psg_pkg::level_t lvl);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (level_table[i] == lvl) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic end_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        end_with_failure();
    endtask

    //////////////////////////////
    // Bus tasks
    //////////////////////////////

    task automatic write_addr(input logic [3:0] addr);
        @(posedge clk);
        a0     <= 1'b1;
        wren   <= 1'b1;
        wrdata <= {4'b0, addr};
        @(posedge clk);
        wren   <= 1'b0;
    endtask

    task automatic write_data(input logic [7:0] data);
        @(posedge clk);
        a0     <= 1'b0;
        wren   <= 1'b1;
        wrdata <= data;
        @(posedge clk);
        wren   <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        write_addr(addr);
        write_data(data);
    endtask

    // Readback sampled mid-cycle
    task automatic read_reg(input logic [3:0] addr, output logic [7:0] data);
        write_addr(addr);
        @(negedge clk);
        data = rddata;
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [7:0] want);
        logic [7:0] got;
        read_reg(addr, got);
        assert (got == want)
            else report_error($sformatf("register %0h read %02h, expected %02h",
                                        addr, got, want));
    endtask

    // Input port readback follows the pins in the same cycle
    task automatic follow_input(input logic [3:0] addr);
        logic [7:0] value;
        write_addr(addr);
        repeat (8) begin
            @(posedge clk);
            value = rand_byte();
            if (addr == 4'hE) begin
                io_a_in <= value;
            end else begin
                io_b_in <= value;
            end
            @(negedge clk);
            assert (rddata == value)
                else report_error($sformatf("port %0h read %02h, expected input %02h",
                                            addr, rddata, value));
        end
    endtask

    task automatic check_output_latch(input logic [3:0] addr);
        logic [7:0] value;
        value = rand_byte();
        write_reg(addr, value);
        // Pins differ from the latch
        if (addr == 4'hE) begin
            io_a_in <= ~value;
        end else begin
            io_b_in <= ~value;
        end
        check_reg(addr, value);
    endtask

    task automatic wait_for_level(input int ch, input psg_pkg::level_t want,
                                  input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout(what);
            end
        end while (channel_level(ch) != want);
    endtask

    task automatic hold_level(input int ch, input psg_pkg::level_t want);
        repeat (4 * PRESCALE_DIV) begin
            @(negedge clk);
            assert (channel_level(ch) == want)
                else report_error($sformatf("channel %0d moved to %0d, expected %0d",
                                            ch, channel_level(ch), want));
        end
    endtask

    //////////////////////////////
    // Output checks
    //////////////////////////////

    levels_in_table: assert property (@(posedge clk) disable iff (reset)
        level_known(ch_a) && level_known(ch_b) && level_known(ch_c))
        else report_error("a channel output is not a level of the volume table");

    tone_full_swing: assert property (@(posedge clk)
        tone_phase |-> (ch_a == 10'd0 || ch_a == 10'd1023))
        else report_error("ch_a left 0 and 1023 while the tone runs");

    env_no_rise: assert property (@(posedge clk)
        (env_falling && $past(env_falling)) |-> (ch_b <= $past(ch_b)))
        else report_error("ch_b rose during the envelope decay");

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        logic [7:0] value;
        logic [3:0] vol [3];
        int         cycles;
        logic       seen_low;
        logic       seen_high;

        level_table = '{10'd0, 10'd6, 10'd9, 10'd13, 10'd19, 10'd27, 10'd39, 10'd56,
                        10'd80, 10'd116, 10'd166, 10'd239, 10'd344, 10'd495, 10'd712,
                        10'd1023};
        a0      = 1'b0;
        wren    = 1'b0;
        wrdata  = 8'h00;
        io_a_in = 8'h00;
        io_b_in = 8'h00;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("the end of reset");
            end
        end while (reset);

        // Reset values
        assert (ch_a == 10'd0 && ch_b == 10'd0 && ch_c == 10'd0)
            else report_error("channel outputs are not 0 after reset");
        for (int r = 0; r < 16; r++) begin
            check_reg(4'(r), (r == 7) ? 8'h3F : 8'h00);
        end

        // Masked readback of registers 0 to D
        for (int r = 0; r < 14; r++) begin
            value = rand_byte();
            write_reg(4'(r), value);
            check_reg(4'(r), value & reg_mask(4'(r)));
        end

        // I/O ports
        write_reg(4'h7, 8'h3F);
        follow_input(4'hE);
        follow_input(4'hF);
        write_reg(4'h7, 8'hFF);
        check_output_latch(4'hE);
        check_output_latch(4'hF);

        // Fixed volumes with tone and noise off
        write_reg(4'h7, 8'h3F);
        for (int c = 0; c < 3; c++) begin
            value  = rand_byte();
            vol[c] = value[3:0];
            write_reg(4'(8 + c), {4'b0, vol[c]});
        end
        for (int c = 0; c < 3; c++) begin
            wait_for_level(c, level_table[vol[c]], "a fixed volume level");
            hold_level(c, level_table[vol[c]]);
        end

        // Tone on channel A at full volume
        write_reg(4'h8, 8'h0F);
        wait_for_level(0, 10'd1023, "ch_a at full scale");
        tone_phase = 1'b1;
        write_reg(4'h0, 8'h02);
        write_reg(4'h1, 8'h00);
        write_reg(4'h7, 8'h3E);
        seen_low  = 1'b0;
        seen_high = 1'b0;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_on_timeout("both tone levels on ch_a");
            end
            if (ch_a == 10'd0) begin
                seen_low = 1'b1;
            end
            if (ch_a == 10'd1023) begin
                seen_high = 1'b1;
            end
        end while (!(seen_low && seen_high));
        write_reg(4'h7, 8'h3F);
        tone_phase = 1'b0;

        // Envelope decay on channel B at the shortest period
        write_reg(4'hB, 8'h00);
        write_reg(4'hC, 8'h00);
        write_reg(4'h9, 8'h10);
        write_reg(4'hD, 8'h00);
        // First decay runs out and stops at 0
        repeat (20 * PRESCALE_DIV) @(posedge clk);
        write_reg(4'hD, 8'h00);
        wait_for_level(1, 10'd1023, "ch_b at full scale on the envelope");
        env_falling = 1'b1;
        wait_for_level(1, 10'd0, "ch_b decaying to 0");
        hold_level(1, 10'd0);
        env_falling = 1'b0;

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog/psg_top.sv
`timescale 1ns/1ps

module psg_top #(
    parameter int PRESCALE_DIV = 128
) (
    input  logic                   clk,
    input  logic                   reset,

    // CPU register port
    input  logic                   a0,
    input  logic                   wren,
    input  logic [7:0]             wrdata,
    output logic [7:0]             rddata,

    input  logic [7:0]             io_a_in,
    input  logic [7:0]             io_b_in,

    output psg_pkg::level_t        ch_a,
    output psg_pkg::level_t        ch_b,
    output psg_pkg::level_t        ch_c
);

    logic             tick;
    logic [2:0]       tone_out;
    logic             noise_bit;
    psg_pkg::volume_t env_volume;

    psg_regs_if regs_bus ();

    psg_regfile regfile_inst (
        .clk        (clk),
        .reset      (reset),
        .a0         (a0),
        .wren       (wren),
        .wrdata     (wrdata),
        .rddata     (rddata),
        .io_a_in    (io_a_in),
        .io_b_in    (io_b_in),
        .regs       (regs_bus.regs)
    );

    psg_tone_bank #(
        .PRESCALE_DIV (PRESCALE_DIV)
    ) tone_bank_inst (
        .clk        (clk),
        .reset      (reset),
        .regs       (regs_bus.tone),
        .tick       (tick),
        .tone_out   (tone_out)
    );

    psg_noise_gen noise_gen_inst (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .regs       (regs_bus.noise),
        .noise_bit  (noise_bit)
    );

    psg_envelope_gen envelope_gen_inst (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .regs       (regs_bus.env),
        .env_volume (env_volume)
    );

    psg_mixer mixer_inst (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .tone_out   (tone_out),
        .noise_bit  (noise_bit),
        .regs       (regs_bus.mix),
        .env_volume (env_volume),
        .ch_a       (ch_a),
        .ch_b       (ch_b),
        .ch_c       (ch_c)
    );

endmodule
